//--- ctrl_decode.sv
`timescale 1ns/1ns
`include "serial_decode_defs.svh"

module ctrl_decode
   import serial_decode_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   input  logic      i_capture,
   input  word_t     i_instr,
   output ctrl_t     o_ctrl,
   output reg_addr_t o_rd_addr
);

   opcode_t opcode;
   funct3_t funct3;
   logic    bit30;

   logic is_opimm;
   logic is_op;
   logic is_lui;
   logic is_branch;
   logic is_alu;
   logic shift_f3;
   logic illegal;

   // Reset state decodes as addi x0, the canonical nop
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         opcode    <= `SD_OPC_OPIMM;
         funct3    <= '0;
         bit30     <= 1'b0;
         o_rd_addr <= '0;
      end else if (i_capture) begin
         opcode    <= i_instr[6:2];
         funct3    <= i_instr[14:12];
         bit30     <= i_instr[30];
         o_rd_addr <= i_instr[11:7];
      end
   end

   assign is_opimm  = (opcode == `SD_OPC_OPIMM);
   assign is_op     = (opcode == `SD_OPC_OP);
   assign is_lui    = (opcode == `SD_OPC_LUI);
   assign is_branch = (opcode == `SD_OPC_BRANCH);
   assign is_alu    = is_opimm | is_op;
   // sll, srl and sra are not implemented
   assign shift_f3  = (funct3[1:0] == 2'b01);

   always_comb begin
      illegal = 1'b1;
      if (is_opimm)
         illegal = shift_f3;
      else if (is_op)
         illegal = shift_f3 | (bit30 & (funct3 != 3'b000));
      else if (is_lui)
         illegal = 1'b0;
      else if (is_branch)
         illegal = (funct3[2:1] == 2'b01);
   end

   always_comb begin
      o_ctrl.op_b_imm = is_opimm | is_lui;
      o_ctrl.zero_a   = is_lui;
      // Compares run through the subtractor as well
      o_ctrl.alu_sub  = (is_op & bit30) | (is_alu & (funct3[2:1] == 2'b01)) | is_branch;
      o_ctrl.bool_en  = is_alu & funct3[2] & ~shift_f3;
      o_ctrl.bool_op  = funct3[1:0];
      o_ctrl.slt_en   = is_alu & (funct3[2:1] == 2'b01);
      // sltu, bltu and bgeu
      o_ctrl.cmp_uns  = (funct3[0] & funct3[1]) | (funct3[1] & funct3[2]);
      o_ctrl.branch   = is_branch & ~illegal;
      o_ctrl.cmp_eq   = (funct3[2:1] == 2'b00);
      o_ctrl.cmp_inv  = funct3[0];
      o_ctrl.rd_we    = (is_alu | is_lui) & (o_rd_addr != '0) & ~illegal;
      o_ctrl.illegal  = illegal;
   end

endmodule

//--- imm_serializer.sv
`timescale 1ns/1ns
`include "serial_decode_defs.svh"

module imm_serializer
   import serial_decode_pkg::*;
(
   input  logic  clk,
   input  logic  i_rst_n,
   input  logic  i_capture,
   input  logic  i_cnt_en,
   input  word_t i_instr,
   input  ctrl_t i_ctrl,
   output logic  o_imm_bit
);

   opcode_t load_opc;
   word_t   imm_load;
   word_t   imm_sr;
   logic    shift_en;

   // Opcode of the word being captured, ctrl is not valid yet
   assign load_opc = i_instr[6:2];

   always_comb begin
      if (load_opc == `SD_OPC_OPIMM)
         // I-type, sign extended from bit 31
         imm_load = {{20{i_instr[31]}}, i_instr[31:20]};
      else if (load_opc == `SD_OPC_LUI)
         // U-type, upper 20 bits over zeros
         imm_load = {i_instr[31:12], 12'b0};
      else
         imm_load = '0;
   end

   // No shifting when operand B comes from rs2
   assign shift_en = i_cnt_en & i_ctrl.op_b_imm;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         imm_sr <= '0;
      end else if (i_capture) begin
         imm_sr <= imm_load;
      end else if (shift_en) begin
         imm_sr <= imm_sr >> 1;
      end
   end

   // LSB first
   assign o_imm_bit = imm_sr[0] & i_ctrl.op_b_imm;

endmodule

//--- instr_sequencer.sv
`timescale 1ns/1ns

module instr_sequencer
   import serial_decode_pkg::*;
(
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_req,
   output logic o_ack,
   output logic o_capture,
   output logic o_cnt_en,
   output logic o_cnt_done
);

   seq_state_e state;
   bit_cnt_t   cnt;

   // Operands are taken at the edge that moves IDLE to RUN
   assign o_capture  = (state == IDLE) && i_req;
   assign o_cnt_en   = (state == RUN);
   assign o_cnt_done = (state == RUN) && (cnt == '1);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= IDLE;
         cnt   <= '0;
         o_ack <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (i_req) begin
                  state <= RUN;
                  cnt   <= '0;
               end
            end
            RUN: begin
               // Counter wraps back to zero after bit 31
               cnt <= cnt + bit_cnt_t'(1);
               if (o_cnt_done) begin
                  state <= DONE;
                  o_ack <= 1'b1;
               end
            end
            DONE: begin
               // Hold results until the requester lets go
               if (!i_req) begin
                  state <= IDLE;
                  o_ack <= 1'b0;
               end
            end
            default: begin
               state <= IDLE;
               o_ack <= 1'b0;
            end
         endcase
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass is decided from the output
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_serial_decode
out=$(./obj_dir/Vtb_serial_decode 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

//--- serial_alu.sv
`timescale 1ns/1ns
`include "serial_decode_defs.svh"

module serial_alu
   import serial_decode_pkg::*;
(
   input  logic  clk,
   input  logic  i_rst_n,
   input  logic  i_capture,
   input  logic  i_cnt_en,
   input  logic  i_cnt_done,
   input  word_t i_rs1,
   input  word_t i_rs2,
   input  ctrl_t i_ctrl,
   input  logic  i_imm_bit,
   output word_t o_rd_data,
   output logic  o_take_branch
);

   word_t rs1_sr;
   word_t rs2_sr;
   word_t rd_sr;
   logic  first;
   logic  carry;
   logic  diff;

   logic  a_bit;
   logic  b_src;
   logic  b_bit;
   logic  c_in;
   logic  sum_bit;
   logic  c_out;
   logic  bool_bit;
   logic  res_bit;
   logic  eq;
   logic  lt;
   logic  cmp;

   assign a_bit = rs1_sr[0] & ~i_ctrl.zero_a;
   assign b_src = i_ctrl.op_b_imm ? i_imm_bit : rs2_sr[0];

   // a - b as a + ~b + 1, the +1 enters as the first carry
   assign b_bit   = b_src ^ i_ctrl.alu_sub;
   assign c_in    = first ? i_ctrl.alu_sub : carry;
   assign sum_bit = a_bit ^ b_bit ^ c_in;
   assign c_out   = (a_bit & b_bit) | (c_in & (a_bit ^ b_bit));

   always_comb begin
      case (i_ctrl.bool_op)
         2'b10:   bool_bit = a_bit | b_src;
         2'b11:   bool_bit = a_bit & b_src;
         default: bool_bit = a_bit ^ b_src;
      endcase
   end

   assign res_bit = i_ctrl.bool_en ? bool_bit : sum_bit;

   // Only meaningful in the last bit cycle, where a_bit and b_src are the signs
   assign eq  = ~(diff | (a_bit ^ b_src));
   assign lt  = (a_bit ^ b_src) ? (i_ctrl.cmp_uns ? b_src : a_bit) : ~c_out;
   assign cmp = i_ctrl.cmp_eq ? eq : lt;

   always_ff @(posedge clk) begin
      if (i_capture) begin
         rs1_sr <= i_rs1;
         rs2_sr <= i_rs2;
      end else if (i_cnt_en) begin
         rs1_sr <= rs1_sr >> 1;
         rs2_sr <= rs2_sr >> 1;
      end
   end

   // Result bits enter from the top and settle into place after 32 shifts
   always_ff @(posedge clk) begin
      if (i_cnt_done && i_ctrl.slt_en) begin
         rd_sr <= {{(`SD_XLEN-1){1'b0}}, lt};
      end else if (i_cnt_en) begin
         rd_sr <= {res_bit, rd_sr[`SD_XLEN-1:1]};
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         first         <= 1'b0;
         carry         <= 1'b0;
         diff          <= 1'b0;
         o_take_branch <= 1'b0;
      end else begin
         if (i_capture) begin
            first <= 1'b1;
            diff  <= 1'b0;
         end else if (i_cnt_en) begin
            first <= 1'b0;
            carry <= c_out;
            diff  <= diff | (a_bit ^ b_src);
         end
         if (i_cnt_done) begin
            o_take_branch <= i_ctrl.branch & (cmp ^ i_ctrl.cmp_inv);
         end
      end
   end

   assign o_rd_data = rd_sr;

endmodule

//--- serial_decode_assertions.sv
`timescale 1ns/1ns

module serial_decode_assertions (
   input logic clk,
   input logic i_rst_n,
   input logic i_req,
   input logic o_ack
);

   // Ack starts low once reset lets go
   ack_low_after_reset: assert property (@(posedge clk) $rose(i_rst_n) |-> !o_ack)
      else $error("o_ack high right after reset release");

   ack_rise_with_req: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(o_ack) |-> $past(i_req))
      else $error("o_ack rose without a pending request");

   // Ack may only drop at the edge that saw req low
   ack_fall_after_req: assert property (@(posedge clk) disable iff (!i_rst_n)
      $fell(o_ack) |-> !$past(i_req))
      else $error("o_ack fell while the request was still high");

endmodule

bind serial_decode_top serial_decode_assertions u_sva (
   .clk     (clk),
   .i_rst_n (i_rst_n),
   .i_req   (i_req),
   .o_ack   (o_ack)
);

//--- serial_decode_defs.svh
`ifndef SERIAL_DECODE_DEFS_SVH
`define SERIAL_DECODE_DEFS_SVH

// Datapath width and serial bit counter width
`define SD_XLEN  32
`define SD_CNT_W 5

// Opcode values, instruction bits 6 to 2
`define SD_OPC_OPIMM  5'b00100
`define SD_OPC_OP     5'b01100
`define SD_OPC_LUI    5'b01101
`define SD_OPC_BRANCH 5'b11000

`endif

//--- serial_decode_pkg.sv
`include "serial_decode_defs.svh"

package serial_decode_pkg;

   typedef logic [`SD_XLEN-1:0]  word_t;
   typedef logic [4:0]           reg_addr_t;
   typedef logic [4:0]           opcode_t;
   typedef logic [2:0]           funct3_t;
   typedef logic [`SD_CNT_W-1:0] bit_cnt_t;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DONE
   } seq_state_e;

   // Decoded control, valid from the edge after capture
   typedef struct packed {
      logic       op_b_imm;
      logic       zero_a;
      logic       alu_sub;
      logic       bool_en;
      logic [1:0] bool_op;
      logic       slt_en;
      logic       cmp_uns;
      logic       branch;
      logic       cmp_eq;
      logic       cmp_inv;
      logic       rd_we;
      logic       illegal;
   } ctrl_t;

endpackage

//--- serial_decode_top.sv
`timescale 1ns/1ns

module serial_decode_top
   import serial_decode_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   input  logic      i_req,
   input  word_t     i_instr,
   input  word_t     i_rs1,
   input  word_t     i_rs2,
   output logic      o_ack,
   output word_t     o_rd_data,
   output reg_addr_t o_rd_addr,
   output logic      o_rd_we,
   output logic      o_take_branch,
   output logic      o_illegal
);

   logic  capture;
   logic  cnt_en;
   logic  cnt_done;
   logic  imm_bit;
   ctrl_t ctrl;

   instr_sequencer u_seq (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_req      (i_req),
      .o_ack      (o_ack),
      .o_capture  (capture),
      .o_cnt_en   (cnt_en),
      .o_cnt_done (cnt_done)
   );

   ctrl_decode u_dec (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_capture (capture),
      .i_instr   (i_instr),
      .o_ctrl    (ctrl),
      .o_rd_addr (o_rd_addr)
   );

   // Runs beside the decoder from the same instruction word
   imm_serializer u_imm (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_capture (capture),
      .i_cnt_en  (cnt_en),
      .i_instr   (i_instr),
      .i_ctrl    (ctrl),
      .o_imm_bit (imm_bit)
   );

   serial_alu u_alu (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_capture     (capture),
      .i_cnt_en      (cnt_en),
      .i_cnt_done    (cnt_done),
      .i_rs1         (i_rs1),
      .i_rs2         (i_rs2),
      .i_ctrl        (ctrl),
      .i_imm_bit     (imm_bit),
      .o_rd_data     (o_rd_data),
      .o_take_branch (o_take_branch)
   );

   assign o_rd_we   = ctrl.rd_we;
   assign o_illegal = ctrl.illegal;

endmodule

//--- tb_serial_decode.sv
`timescale 1ns/1ns
`include "serial_decode_defs.svh"

module tb_serial_decode
   import serial_decode_pkg::*;
();

   localparam int DRV = 5;
   localparam int ACK_WAIT = 40;
   // Requests in the five tests add up to 1 + 23 + 35 + 36 + 12
   localparam int N_REQ = 107;
   localparam int CYCLE_LIMIT = N_REQ * 40 + 100;

   typedef struct packed {
      word_t rd_data;
      logic  rd_we;
      logic  take;
      logic  illegal;
   } result_t;

   logic      clk = 1'b0;
   logic      i_rst_n;
   logic      i_req;
   word_t     i_instr;
   word_t     i_rs1;
   word_t     i_rs2;
   logic      o_ack;
   word_t     o_rd_data;
   reg_addr_t o_rd_addr;
   logic      o_rd_we;
   logic      o_take_branch;
   logic      o_illegal;

   int errors = 0;
   int checks = 0;
   int seed = 6202;
   int cycle_cnt = 0;

   serial_decode_top uut (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_req         (i_req),
      .i_instr       (i_instr),
      .i_rs1         (i_rs1),
      .i_rs2         (i_rs2),
      .o_ack         (o_ack),
      .o_rd_data     (o_rd_data),
      .o_rd_addr     (o_rd_addr),
      .o_rd_we       (o_rd_we),
      .o_take_branch (o_take_branch),
      .o_illegal     (o_illegal)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
         print_summary();
         $display("Test failures found");
         $finish;
      end
   end

   // Reference model for the supported RV32I subset
   function automatic result_t model(word_t instr, word_t a, word_t b);
      result_t r;
      opcode_t opc;
      funct3_t f3;
      word_t   opb;
      opc = instr[6:2];
      f3  = instr[14:12];
      r   = '0;
      r.illegal = 1'b1;
      if (opc == `SD_OPC_OPIMM || opc == `SD_OPC_OP) begin
         opb = (opc == `SD_OPC_OP) ? b : {{20{instr[31]}}, instr[31:20]};
         r.illegal = (f3 == 3'b001) || (f3 == 3'b101) ||
                     (opc == `SD_OPC_OP && instr[30] && f3 != 3'b000);
         case (f3)
            3'b000:  r.rd_data = (opc == `SD_OPC_OP && instr[30]) ? a - opb : a + opb;
            3'b010:  r.rd_data = word_t'($signed(a) < $signed(opb));
            3'b011:  r.rd_data = word_t'(a < opb);
            3'b100:  r.rd_data = a ^ opb;
            3'b110:  r.rd_data = a | opb;
            3'b111:  r.rd_data = a & opb;
            default: r.rd_data = '0;
         endcase
      end else if (opc == `SD_OPC_LUI) begin
         r.illegal = 1'b0;
         r.rd_data = {instr[31:12], 12'b0};
      end else if (opc == `SD_OPC_BRANCH) begin
         r.illegal = (f3 == 3'b010) || (f3 == 3'b011);
         case (f3)
            3'b000:  r.take = (a == b);
            3'b001:  r.take = (a != b);
            3'b100:  r.take = ($signed(a) < $signed(b));
            3'b101:  r.take = ($signed(a) >= $signed(b));
            3'b110:  r.take = (a < b);
            3'b111:  r.take = (a >= b);
            default: r.take = 1'b0;
         endcase
      end
      r.rd_we = !r.illegal && opc != `SD_OPC_BRANCH && instr[11:7] != 5'd0;
      r.take  = r.take && !r.illegal;
      return r;
   endfunction

   // Register file lives outside the DUT so the rs1 and rs2 fields stay fixed
   function automatic word_t enc_i(funct3_t f3, reg_addr_t rd, logic [11:0] imm);
      return {imm, 5'd1, f3, rd, `SD_OPC_OPIMM, 2'b11};
   endfunction

   function automatic word_t enc_r(logic alt, funct3_t f3, reg_addr_t rd, opcode_t opc);
      return {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, rd, opc, 2'b11};
   endfunction

   function automatic word_t enc_u(reg_addr_t rd, logic [19:0] imm);
      return {imm, rd, `SD_OPC_LUI, 2'b11};
   endfunction

   task automatic check_val(input word_t got, input word_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic print_summary();
      $display("Summary: %0d checks, %0d errors", checks, errors);
   endtask

   // Entered and left a few ns after a rising edge while the sequencer is idle
   task automatic do_request(input word_t instr, input word_t a, input word_t b,
                             input int hold);
      result_t exp;
      int      n;
      exp     = model(instr, a, b);
      i_instr = instr;
      i_rs1   = a;
      i_rs2   = b;
      i_req   = 1'b1;
      // Capture edge
      @(posedge clk);
      n = 0;
      do begin
         @(posedge clk);
         n++;
         @(negedge clk);
      end while (!o_ack && n < ACK_WAIT);
      if (!o_ack) begin
         $display("Handshake error at %0t ns: no ack within %0d cycles of capture",
                  $time, ACK_WAIT);
         errors++;
      end else begin
         check_val(word_t'(n), 32, "ack latency");
         check_val(word_t'(o_rd_we), word_t'(exp.rd_we), "rd_we");
         check_val(word_t'(o_take_branch), word_t'(exp.take), "take_branch");
         check_val(word_t'(o_illegal), word_t'(exp.illegal), "illegal");
         if (exp.rd_we) begin
            check_val(o_rd_data, exp.rd_data, "rd_data");
            check_val(word_t'(o_rd_addr), word_t'(instr[11:7]), "rd_addr");
         end
         // Outputs must hold while a slow requester keeps req high
         repeat (hold) begin
            @(negedge clk);
            check_val(word_t'(o_ack), 1, "ack held under back-pressure");
            if (exp.rd_we)
               check_val(o_rd_data, exp.rd_data, "rd_data held");
         end
      end
      @(posedge clk);
      #DRV i_req = 1'b0;
      @(posedge clk);
      @(negedge clk);
      check_val(word_t'(o_ack), 0, "ack after req low");
      @(posedge clk);
      #DRV;
   endtask

   task automatic test_reset_handshake();
      @(negedge clk);
      check_val(word_t'(o_ack), 0, "ack after reset");
      check_val(word_t'(o_rd_we), 0, "rd_we after reset");
      check_val(word_t'(o_take_branch), 0, "take_branch after reset");
      check_val(word_t'(o_illegal), 0, "illegal after reset");
      @(posedge clk);
      #DRV;
      do_request(enc_i(3'b000, 5'd3, 12'h123), 32'h0000_1000, '0, 3);
   endtask

   task automatic test_imm_ops();
      word_t r;
      word_t a;
      for (int i = 0; i < 4; i++) begin
         r = $random(seed);
         a = $random(seed);
         do_request(enc_i(3'b000, 5'd4, {1'b0, r[10:0]}), a, '0, 0);
         do_request(enc_i(3'b000, 5'd5, {1'b1, r[21:11]}), a, '0, 0);
         do_request(enc_i(3'b010, 5'd6, r[31:20]), a, '0, 0);
         do_request(enc_i(3'b011, 5'd7, r[31:20]), a, '0, 0);
         do_request(enc_u(5'd8, r[31:12]), a, '0, 0);
      end
      r = $random(seed);
      a = $random(seed);
      do_request(enc_i(3'b100, 5'd9, r[11:0]), a, '0, 0);
      do_request(enc_i(3'b110, 5'd10, r[11:0]), a, '0, 0);
      do_request(enc_i(3'b111, 5'd11, r[11:0]), a, '0, 0);
   endtask

   task automatic test_reg_ops();
      // {bit 30, funct3} for add, sub, slt, sltu, xor, or, and
      logic [3:0] ops [7] = '{4'b0000, 4'b1000, 4'b0010, 4'b0011,
                              4'b0100, 4'b0110, 4'b0111};
      word_t a;
      for (int i = 0; i < 7; i++) begin
         a = $random(seed);
         do_request(enc_r(ops[i][3], ops[i][2:0], 5'd12, `SD_OPC_OP), a, $random(seed), 0);
         do_request(enc_r(ops[i][3], ops[i][2:0], 5'd13, `SD_OPC_OP), $random(seed), a, 0);
         do_request(enc_r(ops[i][3], ops[i][2:0], 5'd14, `SD_OPC_OP), a, a, 0);
         do_request(enc_r(ops[i][3], ops[i][2:0], 5'd15, `SD_OPC_OP),
                    32'h8000_0000, 32'h7fff_ffff, 0);
         do_request(enc_r(ops[i][3], ops[i][2:0], 5'd31, `SD_OPC_OP),
                    32'hffff_ffff, 32'd1, 0);
      end
   endtask

   task automatic test_branches();
      funct3_t bf3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      // Pairs cover equal, less and greater in both signed and unsigned sense
      word_t   pa  [6] = '{32'd5, 32'd5, 32'd7, 32'hffff_ffff, 32'd1, 32'h8000_0000};
      word_t   pb  [6] = '{32'd5, 32'd7, 32'd5, 32'd1, 32'hffff_ffff, 32'h7fff_ffff};
      for (int i = 0; i < 6; i++) begin
         // Nonzero rd field as in a real branch offset
         for (int j = 0; j < 6; j++)
            do_request(enc_r(1'b0, bf3[i], 5'd17, `SD_OPC_BRANCH), pa[j], pb[j], 0);
      end
   endtask

   task automatic test_illegal();
      word_t a;
      a = $random(seed);
      do_request(enc_i(3'b000, 5'd0, 12'h055), a, '0, 0);
      do_request(enc_r(1'b0, 3'b000, 5'd0, `SD_OPC_OP), a, a, 0);
      // Shifts
      do_request(enc_i(3'b001, 5'd3, 12'h004), a, '0, 0);
      do_request(enc_i(3'b101, 5'd3, 12'h404), a, '0, 0);
      do_request(enc_r(1'b0, 3'b001, 5'd3, `SD_OPC_OP), a, 32'd2, 0);
      do_request(enc_r(1'b1, 3'b101, 5'd3, `SD_OPC_OP), a, 32'd2, 0);
      // Load, store, jal, reserved branch codes, xor with bit 30
      do_request(enc_r(1'b0, 3'b010, 5'd3, 5'b00000), a, a, 0);
      do_request(enc_r(1'b0, 3'b010, 5'd3, 5'b01000), a, a, 0);
      do_request(enc_r(1'b0, 3'b000, 5'd3, 5'b11011), a, a, 0);
      do_request(enc_r(1'b0, 3'b010, 5'd0, `SD_OPC_BRANCH), a, a, 0);
      do_request(enc_r(1'b0, 3'b011, 5'd0, `SD_OPC_BRANCH), a, a, 0);
      do_request(enc_r(1'b1, 3'b100, 5'd3, `SD_OPC_OP), a, a, 0);
   endtask

   initial begin
      i_rst_n = 1'b0;
      i_req   = 1'b0;
      i_instr = '0;
      i_rs1   = '0;
      i_rs2   = '0;
      repeat (5) @(posedge clk);
      #DRV i_rst_n = 1'b1;
      test_reset_handshake();
      test_imm_ops();
      test_reg_ops();
      test_branches();
      test_illegal();
      print_summary();
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+.
serial_decode_pkg.sv
instr_sequencer.sv
ctrl_decode.sv
imm_serializer.sv
serial_alu.sv
serial_decode_top.sv
serial_decode_assertions.sv
tb_serial_decode.sv
